// File: verilog/link_pkg.sv
package link_pkg;

    // Widths with a meaning on the link.
    typedef logic [3:0]  btype_t;
    typedef logic [11:0] payload_t;
    typedef logic [3:0]  chk_t;

    // Packet types.
    localparam btype_t BAG_INIT  = 4'd0;
    localparam btype_t BAG_ACK   = 4'd1;
    localparam btype_t BAG_NAK   = 4'd2;
    localparam btype_t BAG_DATA0 = 4'd13;
    localparam btype_t BAG_ERROR = 4'd15;  // Only marks a corrupt frame.

    // Frame layout, LSB on the wire first:
    // start(0), type[3:0], payload[11:0], check[3:0], stop(1).
    localparam int FRAME_BITS = 22;

    localparam int TYPE_POS  = 1;
    localparam int DATA_POS  = 5;
    localparam int CHK_POS   = 17;
    localparam int STOP_POS  = 21;

    typedef logic [FRAME_BITS-1:0] frame_t;

    // Nibble XOR over type and payload.
    function automatic chk_t frame_chk(
        input btype_t   btype,
        input payload_t data
    );
        chk_t chk;
        chk = btype;
        chk = chk ^ data[3:0];
        chk = chk ^ data[7:4];
        chk = chk ^ data[11:8];
        return chk;
    endfunction

    // Bit string for one frame, bit 0 goes out first.
    function automatic frame_t frame_build(
        input btype_t   btype,
        input payload_t data
    );
        frame_t frame;
        frame = '1;
        frame[0] = 1'b0;
        frame[TYPE_POS +: 4] = btype;
        frame[DATA_POS +: 12] = data;
        frame[CHK_POS +: 4] = frame_chk(btype, data);
        frame[STOP_POS] = 1'b1;
        return frame;
    endfunction

endpackage

// File: verilog/link_if.sv
`timescale 1ns/10ps

// Four-phase packet handshake between the controller and a serial stage.
interface link_if;

    logic              strobe;
    logic              done;
    link_pkg::btype_t   btype;
    link_pkg::payload_t data;

    modport src (
        output strobe,
        output btype,
        output data,
        input  done
    );

    modport dst (
        input  strobe,
        input  btype,
        input  data,
        output done
    );

endinterface

// File: verilog/frame_tx.sv
`timescale 1ns/10ps

module frame_tx #(
    parameter int BIT_CYCLES = 4
) (
    input  logic clk,
    input  logic rst,
    link_if.dst  tx,
    output logic ser_out
);

    localparam int CW = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;
    localparam int BW = $clog2(link_pkg::FRAME_BITS);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SHIFT,
        TX_DONE
    } tx_state_t;

    tx_state_t         state;
    logic [CW-1:0]     cyc_cnt;
    logic [BW-1:0]     bit_cnt;
    link_pkg::frame_t  shift_reg;
    logic              bit_end;

    assign bit_end = (cyc_cnt == CW'(BIT_CYCLES - 1));
    assign ser_out = shift_reg[0];  // Idle shifts in ones.
    assign tx.done = (state == TX_DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= TX_IDLE;
            cyc_cnt   <= '0;
            bit_cnt   <= '0;
            shift_reg <= '1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (tx.strobe) begin
                        shift_reg <= link_pkg::frame_build(tx.btype, tx.data);
                        cyc_cnt   <= '0;
                        bit_cnt   <= '0;
                        state     <= TX_SHIFT;
                    end
                end
                TX_SHIFT: begin
                    if (bit_end) begin
                        cyc_cnt   <= '0;
                        shift_reg <= {1'b1, shift_reg[link_pkg::FRAME_BITS-1:1]};
                        if (bit_cnt == BW'(link_pkg::FRAME_BITS - 1)) begin
                            state <= TX_DONE;  // Stop bit is over.
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                TX_DONE: if (!tx.strobe) state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

    // The source must hold its request until the frame is out.
    a_strobe_held: assert property (@(posedge clk) disable iff (rst)
        $fell(tx.strobe) |-> $past(tx.done));

endmodule

// File: verilog/frame_rx.sv
`timescale 1ns/10ps

module frame_rx #(
    parameter int BIT_CYCLES = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic ser_in,
    link_if.src  rx
);

    localparam int CW   = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;
    localparam int BW   = $clog2(link_pkg::FRAME_BITS);
    localparam int HALF = BIT_CYCLES / 2;
    localparam int NB   = link_pkg::FRAME_BITS - 1;  // Bits after the start bit.

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_BITS,
        RX_STROBE,
        RX_RELEASE
    } rx_state_t;

    rx_state_t         state;
    logic              sync_1, sync_2, sync_3;
    logic              start_fall;
    logic [CW-1:0]     cyc_cnt;
    logic [BW-1:0]     bit_cnt;
    logic [NB-1:0]     shift_reg;
    logic [NB-1:0]     bits_next;
    link_pkg::btype_t   btype_n;
    link_pkg::payload_t data_n;
    link_pkg::chk_t     chk_n;
    logic              frame_ok;

    // Two-flop synchronizer, third flop for the edge.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_1 <= 1'b1;
            sync_2 <= 1'b1;
            sync_3 <= 1'b1;
        end else begin
            sync_1 <= ser_in;
            sync_2 <= sync_1;
            sync_3 <= sync_2;
        end
    end

    assign start_fall = sync_3 && !sync_2;

    // Fields as they stand once the stop bit is shifted in.
    assign bits_next = {sync_2, shift_reg[NB-1:1]};
    assign btype_n   = bits_next[3:0];
    assign data_n    = bits_next[15:4];
    assign chk_n     = bits_next[19:16];
    assign frame_ok  = bits_next[NB-1] && (chk_n == link_pkg::frame_chk(btype_n, data_n));

    assign rx.strobe = (state == RX_STROBE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= RX_IDLE;
            cyc_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (start_fall) begin
                        cyc_cnt <= CW'(1);  // Edge cycle counts as the first.
                        state   <= RX_START;
                    end
                end
                RX_START: begin
                    if (cyc_cnt == CW'(HALF)) begin
                        cyc_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= sync_2 ? RX_IDLE : RX_BITS;  // High again is a glitch.
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                RX_BITS: begin
                    if (cyc_cnt == CW'(BIT_CYCLES - 1)) begin
                        cyc_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BW'(NB - 1)) state <= RX_STROBE;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                RX_STROBE: if (rx.done) state <= RX_RELEASE;
                RX_RELEASE: if (!rx.done) state <= RX_IDLE;
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_BITS && cyc_cnt == CW'(BIT_CYCLES - 1)) begin
            shift_reg <= bits_next;
            if (bit_cnt == BW'(NB - 1)) begin
                rx.btype <= frame_ok ? btype_n : link_pkg::BAG_ERROR;
                rx.data  <= data_n;
            end
        end
    end

endmodule

// File: verilog/link_cs.sv
`timescale 1ns/10ps

module link_cs #(
    parameter int TIMEOUT   = 256,
    parameter int MAX_TRIES = 4
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               send_req,
    input  link_pkg::btype_t   send_btype,
    input  link_pkg::payload_t send_data,
    output logic               send_done,
    output logic               send_ok,

    output logic               read_valid,
    output link_pkg::btype_t   read_btype,
    output link_pkg::payload_t read_data,
    input  logic               read_ack,

    link_if.src                tx,
    link_if.dst                rx
);

    localparam int TW  = $clog2(TIMEOUT + 1);
    localparam int TRW = $clog2(MAX_TRIES + 1);

    typedef enum logic [3:0] {
        CS_IDLE,
        CS_WAIT,
        CS_SEND_PREP,
        CS_SEND_DATA,
        CS_ANS_WAIT,
        CS_ANS_TAKE,
        CS_ANS_DONE,
        CS_SEND_DONE,
        CS_READ_PREP,
        CS_READ_DATA,
        CS_REPLY_PREP,
        CS_REPLY_DATA,
        CS_READ_DONE
    } cs_state_t;

    cs_state_t state, next_state;

    logic [TW-1:0]  time_cnt;
    logic [TRW-1:0] tries;
    logic           ans_retry;  // Decision taken from the last answer.
    logic           time_up;

    assign time_up = (time_cnt == TW'(TIMEOUT - 1));

    assign send_done  = (state == CS_SEND_DONE);
    assign read_valid = (state == CS_READ_DONE);
    assign tx.strobe  = (state == CS_SEND_DATA) || (state == CS_REPLY_DATA);
    assign rx.done    = (state == CS_ANS_DONE) || (state == CS_READ_DATA);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= CS_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            CS_IDLE: next_state = CS_WAIT;
            CS_WAIT: begin
                if (send_req) begin
                    next_state = CS_SEND_PREP;  // Sends win a tie.
                end else if (rx.strobe) begin
                    next_state = CS_READ_PREP;
                end
            end
            CS_SEND_PREP: next_state = CS_SEND_DATA;
            CS_SEND_DATA: if (tx.done) next_state = CS_ANS_WAIT;
            CS_ANS_WAIT: begin
                if (rx.strobe) begin
                    next_state = CS_ANS_TAKE;
                end else if (time_up) begin
                    next_state = CS_SEND_DONE;
                end
            end
            CS_ANS_TAKE: next_state = CS_ANS_DONE;
            CS_ANS_DONE: begin
                if (!rx.strobe) begin
                    next_state = ans_retry ? CS_SEND_DATA : CS_SEND_DONE;
                end
            end
            CS_SEND_DONE: if (!send_req) next_state = CS_WAIT;
            CS_READ_PREP: next_state = CS_READ_DATA;
            CS_READ_DATA: if (!rx.strobe) next_state = CS_REPLY_PREP;
            CS_REPLY_PREP: next_state = CS_REPLY_DATA;
            CS_REPLY_DATA: if (tx.done) next_state = CS_READ_DONE;
            CS_READ_DONE: if (read_ack) next_state = CS_WAIT;
            default: next_state = CS_IDLE;
        endcase
    end

    // Answer wait timer, runs only in the wait state.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            time_cnt <= '0;
        end else if (state == CS_ANS_WAIT) begin
            time_cnt <= time_cnt + 1'b1;
        end else begin
            time_cnt <= '0;
        end
    end

    // Try counter and the outcome of each answer.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tries     <= '0;
            ans_retry <= 1'b0;
            send_ok   <= 1'b0;
        end else begin
            case (state)
                CS_SEND_PREP: begin
                    tries     <= TRW'(1);
                    ans_retry <= 1'b0;
                    send_ok   <= 1'b0;
                end
                CS_ANS_TAKE: begin
                    send_ok   <= (rx.btype == link_pkg::BAG_ACK);
                    ans_retry <= (rx.btype != link_pkg::BAG_ACK) && (tries < TRW'(MAX_TRIES));
                end
                CS_ANS_DONE: if (!rx.strobe && ans_retry) tries <= tries + 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx.btype <= link_pkg::BAG_INIT;
        end else if (state == CS_SEND_PREP) begin
            tx.btype <= send_btype;
        end else if (state == CS_REPLY_PREP) begin
            // NAK a corrupt frame, ACK anything else.
            tx.btype <= (read_btype == link_pkg::BAG_ERROR) ? link_pkg::BAG_NAK
                                                            : link_pkg::BAG_ACK;
        end
    end

    always_ff @(posedge clk) begin
        if (state == CS_SEND_PREP) begin
            tx.data <= send_data;
        end else if (state == CS_REPLY_PREP) begin
            tx.data <= '0;  // Replies carry no payload.
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_btype <= link_pkg::BAG_INIT;
        end else if (state == CS_READ_PREP) begin
            read_btype <= rx.btype;
        end
    end

    always_ff @(posedge clk) begin
        if (state == CS_READ_PREP) begin
            read_data <= rx.data;
        end
    end

    // The host holds its request until the send is finished.
    a_send_held: assert property (@(posedge clk) disable iff (rst)
        $fell(send_req) |-> $past(send_done));

endmodule

// File: verilog/link_top.sv
`timescale 1ns/10ps

module link_top #(
    parameter int BIT_CYCLES = 4,
    parameter int TIMEOUT    = 256,
    parameter int MAX_TRIES  = 4
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               send_req,
    input  link_pkg::btype_t   send_btype,
    input  link_pkg::payload_t send_data,
    output logic               send_done,
    output logic               send_ok,

    output logic               read_valid,
    output link_pkg::btype_t   read_btype,
    output link_pkg::payload_t read_data,
    input  logic               read_ack,

    output logic               ser_out,
    input  logic               ser_in
);

    link_if tx_link ();
    link_if rx_link ();

    link_cs #(
        .TIMEOUT   (TIMEOUT),
        .MAX_TRIES (MAX_TRIES)
    ) u_cs (
        .clk        (clk),
        .rst        (rst),
        .send_req   (send_req),
        .send_btype (send_btype),
        .send_data  (send_data),
        .send_done  (send_done),
        .send_ok    (send_ok),
        .read_valid (read_valid),
        .read_btype (read_btype),
        .read_data  (read_data),
        .read_ack   (read_ack),
        .tx         (tx_link.src),
        .rx         (rx_link.dst)
    );

    frame_tx #(.BIT_CYCLES(BIT_CYCLES)) u_tx (
        .clk     (clk),
        .rst     (rst),
        .tx      (tx_link.dst),
        .ser_out (ser_out)
    );

    frame_rx #(.BIT_CYCLES(BIT_CYCLES)) u_rx (
        .clk    (clk),
        .rst    (rst),
        .ser_in (ser_in),
        .rx     (rx_link.src)
    );

endmodule

// File: test/tb_clk.sv
`timescale 1ns/10ps

// Free running clock and a reset held for the first few edges.
module tb_clk #(
    parameter real PERIOD     = 8.0,
    parameter int  RST_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;  // Released just after an edge.
    end

endmodule

// File: test/tb_link.sv
`timescale 1ns/10ps

module tb_link;

    localparam int BIT_CYCLES = 4;
    localparam int TIMEOUT    = 256;
    localparam int MAX_TRIES  = 4;
    localparam int FBITS      = link_pkg::FRAME_BITS;
    localparam int TURNAROUND = 20;
    localparam int N_ACKS     = 8;
    localparam int N_READS    = 4;
    localparam int N_XFERS    = N_ACKS + 3 + N_READS + 1;
    localparam int WATCHDOG   = N_XFERS * MAX_TRIES * (FBITS * BIT_CYCLES + TIMEOUT) + 2000;

    logic clk, rst;
    logic send_req, send_done, send_ok, read_valid, read_ack, ser_out, ser_in;
    link_pkg::btype_t   send_btype, read_btype;
    link_pkg::payload_t send_data, read_data;

    logic [FBITS-1:0] seen_q[$];  // Frames decoded from ser_out.
    int          frame_cnt = 0;
    int          stop_cycle = 0;
    int          cycle_cnt = 0;
    int          nak_left = 0;
    bit          ack_en = 0;
    int          checks = 0;
    int          errors = 0;
    logic [31:0] rng;

    tb_clk #(.PERIOD(8.0), .RST_CYCLES(4)) u_clk (.clk(clk), .rst(rst));

    link_top #(
        .BIT_CYCLES (BIT_CYCLES),
        .TIMEOUT    (TIMEOUT),
        .MAX_TRIES  (MAX_TRIES)
    ) dut (
        .clk(clk), .rst(rst),
        .send_req(send_req), .send_btype(send_btype), .send_data(send_data),
        .send_done(send_done), .send_ok(send_ok),
        .read_valid(read_valid), .read_btype(read_btype), .read_data(read_data),
        .read_ack(read_ack), .ser_out(ser_out), .ser_in(ser_in)
    );

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Reference frame: start, type, payload, nibble XOR check, stop. LSB leaves first.
    function automatic logic [FBITS-1:0] encode_frame(input logic [3:0] t, input logic [11:0] d);
        logic [3:0] chk;
        chk = t ^ d[3:0] ^ d[7:4] ^ d[11:8];
        return {1'b1, chk, d, t, 1'b0};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    // Peer transmitter, one bit per BIT_CYCLES clocks.
    task automatic drive_frame(input logic [3:0] t, input logic [11:0] d, input bit corrupt);
        logic [FBITS-1:0] bits;
        bits = encode_frame(t, d);
        if (corrupt) bits[17] = ~bits[17];  // Flips a check bit.
        @(posedge clk);
        for (int i = 0; i < FBITS; i++) begin
            #1 ser_in = bits[i];
            repeat (BIT_CYCLES) @(posedge clk);
        end
        #1 ser_in = 1'b1;
    endtask

    task automatic send_packet(input logic [3:0] t, input logic [11:0] d,
                               output logic ok, output int done_cycle);
        @(posedge clk);
        #1;
        send_req   = 1'b1;
        send_btype = t;
        send_data  = d;
        @(negedge clk);
        while (!send_done) @(negedge clk);
        ok         = send_ok;
        done_cycle = cycle_cnt;
        @(posedge clk);
        #1 send_req = 1'b0;
        @(negedge clk);
        while (send_done) @(negedge clk);
        repeat (8) @(posedge clk);
    endtask

    task automatic take_read(input string name, input logic [3:0] t, input logic [11:0] d,
                             input bit corrupt);
        int delay;
        seen_q.delete();
        drive_frame(t, d, corrupt);
        @(negedge clk);
        while (!read_valid) @(negedge clk);
        check_value({name, "_btype"}, corrupt ? link_pkg::BAG_ERROR : t, read_btype);
        if (!corrupt) check_value({name, "_data"}, d, read_data);
        check_value({name, "_reply_count"}, 1, seen_q.size());
        if (seen_q.size() > 0) begin
            check_value({name, "_reply"},
                        encode_frame(corrupt ? link_pkg::BAG_NAK : link_pkg::BAG_ACK, 12'h0),
                        seen_q[0]);
        end
        delay = int'(next_rand() % 8);
        @(posedge clk);
        repeat (delay) @(posedge clk);
        #1 read_ack = 1'b1;
        @(posedge clk);
        #1 read_ack = 1'b0;
        @(negedge clk);
        while (read_valid) @(negedge clk);
    endtask

    // Peer receiver, samples ser_out in the middle of each bit.
    initial begin : peer_decode
        logic [FBITS-1:0] bits;
        forever begin
            @(negedge clk);
            if (!rst && ser_out == 1'b0) begin
                repeat (BIT_CYCLES / 2) @(negedge clk);
                for (int i = 0; i < FBITS; i++) begin
                    bits[i] = ser_out;
                    if (i < FBITS - 1) repeat (BIT_CYCLES) @(negedge clk);
                end
                seen_q.push_back(bits);
                stop_cycle = cycle_cnt;
                frame_cnt++;
            end
        end
    end

    // Peer answer after its turnaround.
    initial begin : peer_answer
        int handled;
        handled = 0;
        forever begin
            wait (frame_cnt != handled);
            handled = frame_cnt;
            if (nak_left > 0) begin
                nak_left--;
                repeat (TURNAROUND) @(posedge clk);
                drive_frame(link_pkg::BAG_NAK, 12'h0, 1'b0);
            end else if (ack_en) begin
                repeat (TURNAROUND) @(posedge clk);
                drive_frame(link_pkg::BAG_ACK, 12'h0, 1'b0);
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG) @(posedge clk);
        $display("Watchdog: the run did not finish within %0d clock cycles", WATCHDOG);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main
        logic [31:0] r;
        logic [3:0]  t;
        logic [11:0] d;
        logic        ok;
        int          dc;
        send_req   = 1'b0;
        send_btype = '0;
        send_data  = '0;
        read_ack   = 1'b0;
        ser_in     = 1'b1;
        rng        = 32'd27133;
        @(negedge clk);
        while (rst) @(negedge clk);
        check_value("reset_ser_out", 1, ser_out);
        check_value("reset_send_done", 0, send_done);
        check_value("reset_read_valid", 0, read_valid);
        check_value("reset_read_btype", link_pkg::BAG_INIT, read_btype);
        repeat (4) @(posedge clk);

        ack_en = 1'b1;
        for (int i = 0; i < N_ACKS; i++) begin
            r = next_rand();
            t = (r[15:12] == link_pkg::BAG_ERROR) ? link_pkg::BAG_DATA0 : r[15:12];
            d = r[11:0];
            seen_q.delete();
            send_packet(t, d, ok, dc);
            check_value("ack_count", 1, seen_q.size());
            if (seen_q.size() > 0) check_value("ack_frame", encode_frame(t, d), seen_q[0]);
            check_value("ack_ok", 1, ok);
        end

        // One NAK, then ACK.
        r = next_rand();
        d = r[11:0];
        seen_q.delete();
        nak_left = 1;
        send_packet(link_pkg::BAG_DATA0, d, ok, dc);
        check_value("nak_once_count", 2, seen_q.size());
        foreach (seen_q[k]) check_value("nak_once_frame", encode_frame(4'd13, d), seen_q[k]);
        check_value("nak_once_ok", 1, ok);

        ack_en = 1'b0;
        r = next_rand();
        d = r[11:0];
        seen_q.delete();
        nak_left = 1000;
        send_packet(link_pkg::BAG_DATA0, d, ok, dc);
        nak_left = 0;
        check_value("retry_count", MAX_TRIES, seen_q.size());
        foreach (seen_q[k]) check_value("retry_frame", encode_frame(4'd13, d), seen_q[k]);
        check_value("retry_ok", 0, ok);

        // Silent peer.
        r = next_rand();
        d = r[11:0];
        seen_q.delete();
        send_packet(link_pkg::BAG_DATA0, d, ok, dc);
        check_value("silent_count", 1, seen_q.size());
        check_value("silent_ok", 0, ok);
        checks++;
        assert (dc - stop_cycle >= TIMEOUT) else begin
            errors++;
            $display("CHECK FAILED silent_wait: expected at least %0d, actual %0d",
                     TIMEOUT, dc - stop_cycle);
        end

        for (int i = 0; i < N_READS; i++) begin
            r = next_rand();
            t = (r[15:12] == link_pkg::BAG_ERROR) ? link_pkg::BAG_DATA0 : r[15:12];
            take_read("read_good", t, r[11:0], 1'b0);
        end
        r = next_rand();
        take_read("read_corrupt", link_pkg::BAG_DATA0, r[11:0], 1'b1);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: compile.f
verilog/link_pkg.sv
verilog/link_if.sv
verilog/frame_tx.sv
verilog/frame_rx.sv
verilog/link_cs.sv
verilog/link_top.sv
test/tb_clk.sv
test/tb_link.sv

// File: run.sh
#!/bin/sh
# Builds the link testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_link -f compile.f -o sim_link

out=$(./obj_dir/sim_link)
echo "$out"

# The run passes only when the pass line was printed.
echo "$out" | grep -q "^TEST RESULT: PASS$"
